// ==== all.f ====
+incdir+sim
rtl/rv_id_pkg.sv
rtl/inst_decoder.sv
rtl/operand_bypass.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
sim/tb_id_stage.sv

// ==== rtl/id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg import rv_id_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   rdy_i,
    input  logic   stall_i,
    input  id_ex_t next_i,
    output id_ex_t id_ex_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id_ex_o <= ID_EX_BUBBLE;
        end else if (rdy_i) begin
            id_ex_o <= stall_i ? ID_EX_BUBBLE : next_i; // hold when not ready.
        end
    end

    // a load-use stall must reach execute as a bubble
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rdy_i && stall_i) |=> (!id_ex_o.we && id_ex_o.op == EX_NOP))
        else $error("id_ex: stall did not insert a bubble");

    // back-pressure freezes the whole stage output.
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !rdy_i |=> $stable(id_ex_o))
        else $error("id_ex: output changed while not ready");

endmodule

`default_nettype wire

// ==== rtl/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage import rv_id_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     rdy_i,
    input  word_t    pc_i,
    input  word_t    inst_i,
    input  word_t    rf_data1_i,
    input  word_t    rf_data2_i,
    input  fwd_t     ex_fwd_i,
    input  fwd_t     mem_fwd_i,
    input  mem_op_e  ex_mem_op_i,
    output rf_read_t rf_read_o,
    output logic     id_stall_o,
    output id_ex_t   id_ex_o
);

    decode_t dec;
    word_t   op1;
    word_t   op2;
    logic    stall1;
    logic    stall2;
    id_ex_t  next;

    inst_decoder u_dec (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    operand_bypass u_src1 (
        .read_en_i   (dec.re1),
        .addr_i      (dec.rs1),
        .imm_i       (dec.imm),
        .rf_data_i   (rf_data1_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .ex_mem_op_i (ex_mem_op_i),
        .operand_o   (op1),
        .stall_o     (stall1)
    );

    operand_bypass u_src2 (
        .read_en_i   (dec.re2),
        .addr_i      (dec.rs2),
        .imm_i       (dec.imm),
        .rf_data_i   (rf_data2_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .ex_mem_op_i (ex_mem_op_i),
        .operand_o   (op2),
        .stall_o     (stall2)
    );

    assign rf_read_o  = '{re1: dec.re1, re2: dec.re2, addr1: dec.rs1, addr2: dec.rs2};
    assign id_stall_o = stall1 | stall2;

    assign next = '{op: dec.op, sel: dec.sel, op1: op1, op2: op2, pc: pc_i,
                    offset: dec.imm, we: dec.we, rd: dec.rd};

    id_ex_reg u_id_ex (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rdy_i   (rdy_i),
        .stall_i (id_stall_o),
        .next_i  (next),
        .id_ex_o (id_ex_o)
    );

endmodule

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import rv_id_pkg::*; (
    input  word_t   inst_i,
    output decode_t dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      imm_i;
    word_t      imm_sh;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];

    assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_sh = {27'b0, rs2}; // shamt.
    assign imm_s  = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b  = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                     inst_i[11:8], 1'b0};
    assign imm_u  = {inst_i[31:12], 12'b0};
    assign imm_j  = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                     inst_i[30:21], 1'b0};

    always_comb begin
        dec_o     = '0;
        dec_o.op  = EX_NOP;
        dec_o.sel = RES_NOP;
        dec_o.rd  = rd;
        case (opcode)
            OP_IMM: begin
                dec_o.re1 = 1'b1;
                dec_o.rs1 = rs1;
                dec_o.we  = 1'b1;
                dec_o.imm = imm_i;
                case (funct3)
                    F3_ADD:  {dec_o.op, dec_o.sel} = {EX_ADD, RES_ARITH};
                    F3_SLT:  {dec_o.op, dec_o.sel} = {EX_SLT, RES_ARITH};
                    F3_SLTU: {dec_o.op, dec_o.sel} = {EX_SLTU, RES_ARITH};
                    F3_XOR:  {dec_o.op, dec_o.sel} = {EX_XOR, RES_LOGIC};
                    F3_OR:   {dec_o.op, dec_o.sel} = {EX_OR, RES_LOGIC};
                    F3_AND:  {dec_o.op, dec_o.sel} = {EX_AND, RES_LOGIC};
                    F3_SLL: begin
                        {dec_o.op, dec_o.sel} = {EX_SLL, RES_SHIFT};
                        dec_o.imm = imm_sh;
                    end
                    F3_SRL: begin
                        dec_o.imm = imm_sh;
                        if (funct7 == F7_BASE) begin
                            {dec_o.op, dec_o.sel} = {EX_SRL, RES_SHIFT};
                        end else if (funct7 == F7_ALT) begin
                            {dec_o.op, dec_o.sel} = {EX_SRA, RES_SHIFT};
                        end
                    end
                endcase
            end
            OP_OP: begin
                dec_o.re1 = 1'b1;
                dec_o.re2 = 1'b1;
                dec_o.rs1 = rs1;
                dec_o.rs2 = rs2;
                dec_o.we  = 1'b1;
                case (funct3)
                    F3_SLL:  {dec_o.op, dec_o.sel} = {EX_SLL, RES_SHIFT};
                    F3_SLT:  {dec_o.op, dec_o.sel} = {EX_SLT, RES_ARITH};
                    F3_SLTU: {dec_o.op, dec_o.sel} = {EX_SLTU, RES_ARITH};
                    F3_XOR:  {dec_o.op, dec_o.sel} = {EX_XOR, RES_LOGIC};
                    F3_OR:   {dec_o.op, dec_o.sel} = {EX_OR, RES_LOGIC};
                    F3_AND:  {dec_o.op, dec_o.sel} = {EX_AND, RES_LOGIC};
                    F3_ADD: begin
                        if (funct7 == F7_BASE) begin
                            {dec_o.op, dec_o.sel} = {EX_ADD, RES_ARITH};
                        end else if (funct7 == F7_ALT) begin
                            {dec_o.op, dec_o.sel} = {EX_SUB, RES_ARITH};
                        end
                    end
                    F3_SRL: begin
                        if (funct7 == F7_BASE) begin
                            {dec_o.op, dec_o.sel} = {EX_SRL, RES_SHIFT};
                        end else if (funct7 == F7_ALT) begin
                            {dec_o.op, dec_o.sel} = {EX_SRA, RES_SHIFT};
                        end
                    end
                endcase
            end
            OP_LUI: begin
                {dec_o.op, dec_o.sel} = {EX_OR, RES_LOGIC}; // imm | imm.
                dec_o.we  = 1'b1;
                dec_o.imm = imm_u;
            end
            OP_AUIPC: begin
                {dec_o.op, dec_o.sel} = {EX_AUIPC, RES_ARITH};
                dec_o.we  = 1'b1;
                dec_o.imm = imm_u;
            end
            OP_JAL: begin
                {dec_o.op, dec_o.sel} = {EX_JAL, RES_JAL};
                dec_o.we  = 1'b1;
                dec_o.imm = imm_j;
            end
            OP_JALR: begin
                {dec_o.op, dec_o.sel} = {EX_JALR, RES_JAL};
                dec_o.re1 = 1'b1;
                dec_o.rs1 = rs1;
                dec_o.we  = 1'b1;
                dec_o.imm = imm_i;
            end
            OP_BRANCH: begin
                dec_o.re1 = 1'b1;
                dec_o.re2 = 1'b1;
                dec_o.rs1 = rs1;
                dec_o.rs2 = rs2;
                dec_o.imm = imm_b;
                case (funct3)
                    F3_BEQ:  dec_o.op = EX_BEQ;
                    F3_BNE:  dec_o.op = EX_BNE;
                    F3_BLT:  dec_o.op = EX_BLT;
                    F3_BGE:  dec_o.op = EX_BGE;
                    F3_BLTU: dec_o.op = EX_BLTU;
                    F3_BGEU: dec_o.op = EX_BGEU;
                    default: dec_o.op = EX_NOP;
                endcase
            end
            OP_LOAD: begin
                dec_o.re1 = 1'b1;
                dec_o.rs1 = rs1;
                dec_o.we  = 1'b1;
                dec_o.imm = imm_i;
                dec_o.sel = RES_MEM;
                case (funct3)
                    F3_LB:   dec_o.op = EX_LB;
                    F3_LH:   dec_o.op = EX_LH;
                    F3_LW:   dec_o.op = EX_LW;
                    F3_LBU:  dec_o.op = EX_LBU;
                    F3_LHU:  dec_o.op = EX_LHU;
                    default: dec_o.op = EX_NOP;
                endcase
            end
            OP_STORE: begin
                dec_o.re1 = 1'b1;
                dec_o.re2 = 1'b1;
                dec_o.rs1 = rs1;
                dec_o.rs2 = rs2;
                dec_o.imm = imm_s;
                dec_o.sel = RES_MEM;
                case (funct3)
                    F3_SB:   dec_o.op = EX_SB;
                    F3_SH:   dec_o.op = EX_SH;
                    F3_SW:   dec_o.op = EX_SW;
                    default: dec_o.op = EX_NOP;
                endcase
            end
            default: ;
        endcase

        // illegal encodings read and write nothing but keep rd
        if (dec_o.op == EX_NOP) begin
            dec_o.sel = RES_NOP;
            dec_o.we  = 1'b0;
            dec_o.re1 = 1'b0;
            dec_o.re2 = 1'b0;
            dec_o.rs1 = '0;
            dec_o.rs2 = '0;
            dec_o.imm = '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/operand_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_bypass import rv_id_pkg::*; (
    input  logic      read_en_i,
    input  reg_addr_t addr_i,
    input  word_t     imm_i,
    input  word_t     rf_data_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    input  mem_op_e   ex_mem_op_i,
    output word_t     operand_o,
    output logic      stall_o
);

    logic ex_load;

    assign ex_load = (ex_mem_op_i == MEM_READ) || (ex_mem_op_i == MEM_READU);

    always_comb begin
        operand_o = rf_data_i;
        stall_o   = 1'b0;
        if (!read_en_i) begin
            operand_o = imm_i;
        end else if (addr_i == '0) begin
            operand_o = '0; // x0.
        end else if (ex_load && ex_fwd_i.rd == addr_i) begin
            operand_o = '0; // load data not there yet.
            stall_o   = 1'b1;
        end else if (ex_fwd_i.we && ex_fwd_i.rd == addr_i) begin
            operand_o = ex_fwd_i.data;
        end else if (mem_fwd_i.we && mem_fwd_i.rd == addr_i) begin
            operand_o = mem_fwd_i.data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_id_pkg.sv ====
`default_nettype none

package rv_id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes.
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD  = 3'b000; // also addi, sub.
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101; // also sra.
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub and sra.

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [4:0] {
        EX_NOP, EX_ADD, EX_SUB, EX_SLL, EX_SLT, EX_SLTU, EX_XOR, EX_SRL,
        EX_SRA, EX_OR, EX_AND, EX_AUIPC, EX_JAL, EX_JALR,
        EX_BEQ, EX_BNE, EX_BLT, EX_BGE, EX_BLTU, EX_BGEU,
        EX_LB, EX_LH, EX_LW, EX_LBU, EX_LHU, EX_SB, EX_SH, EX_SW
    } ex_op_e;

    typedef enum logic [2:0] {
        RES_NOP, RES_LOGIC, RES_SHIFT, RES_ARITH, RES_JAL, RES_MEM
    } ex_sel_e;

    // memory op of the instruction currently in execute.
    typedef enum logic [1:0] {
        MEM_NONE, MEM_READ, MEM_READU, MEM_WRITE
    } mem_op_e;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic      re1;
        logic      re2;
        reg_addr_t addr1;
        reg_addr_t addr2;
    } rf_read_t;

    typedef struct packed {
        ex_op_e    op;
        ex_sel_e   sel;
        reg_addr_t rd;
        logic      we;
        logic      re1;
        logic      re2;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
    } decode_t;

    typedef struct packed {
        ex_op_e    op;
        ex_sel_e   sel;
        word_t     op1;
        word_t     op2;
        word_t     pc;
        word_t     offset;
        logic      we;
        reg_addr_t rd;
    } id_ex_t;

    localparam id_ex_t ID_EX_BUBBLE = '{op: EX_NOP, sel: RES_NOP, default: '0};

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_id_stage -o tb_sim

status=0
./obj_dir/tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: errors found" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"

// ==== sim/id_model.svh ====
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// result group of each execute operation.
function automatic ex_sel_e group_of(ex_op_e op);
    case (op)
        EX_ADD, EX_SUB, EX_SLT, EX_SLTU, EX_AUIPC: return RES_ARITH;
        EX_SLL, EX_SRL, EX_SRA:                    return RES_SHIFT;
        EX_XOR, EX_OR, EX_AND:                     return RES_LOGIC;
        EX_JAL, EX_JALR:                           return RES_JAL;
        EX_LB, EX_LH, EX_LW, EX_LBU, EX_LHU,
        EX_SB, EX_SH, EX_SW:                       return RES_MEM;
        default:                                   return RES_NOP; // nop and branches.
    endcase
endfunction

function automatic ex_op_e alu_op_of(logic [2:0] f3, logic [6:0] f7, logic reg_form);
    case (f3)
        3'b000:  return (!reg_form || f7 == F7_BASE) ? EX_ADD :
                        (f7 == F7_ALT) ? EX_SUB : EX_NOP;
        3'b001:  return EX_SLL;
        3'b010:  return EX_SLT;
        3'b011:  return EX_SLTU;
        3'b100:  return EX_XOR;
        3'b101:  return (f7 == F7_BASE) ? EX_SRL : (f7 == F7_ALT) ? EX_SRA : EX_NOP;
        3'b110:  return EX_OR;
        default: return EX_AND;
    endcase
endfunction

// branch, load and store share the funct3 column.
function automatic ex_op_e branch_mem_op(logic [6:0] opc, logic [2:0] f3);
    logic is_br;
    logic is_ld;
    is_br = (opc == OP_BRANCH);
    is_ld = (opc == OP_LOAD);
    case (f3)
        3'b000:  return is_br ? EX_BEQ : is_ld ? EX_LB : EX_SB;
        3'b001:  return is_br ? EX_BNE : is_ld ? EX_LH : EX_SH;
        3'b010:  return is_br ? EX_NOP : is_ld ? EX_LW : EX_SW;
        3'b100:  return is_br ? EX_BLT : is_ld ? EX_LBU : EX_NOP;
        3'b101:  return is_br ? EX_BGE : is_ld ? EX_LHU : EX_NOP;
        3'b110:  return is_br ? EX_BLTU : EX_NOP;
        3'b111:  return is_br ? EX_BGEU : EX_NOP;
        default: return EX_NOP;
    endcase
endfunction

function automatic decode_t decode_expect(word_t inst);
    decode_t    d;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm_itype;
    f3        = inst[14:12];
    f7        = inst[31:25];
    imm_itype = {{21{inst[31]}}, inst[30:20]};
    d         = '0;
    d.rd      = inst[11:7];
    d.rs1     = inst[19:15];
    d.rs2     = inst[24:20];
    case (inst[6:0])
        OP_IMM: begin
            d.op  = alu_op_of(f3, f7, 1'b0);
            d.imm = (f3[1:0] == 2'b01) ? {27'd0, inst[24:20]} : imm_itype; // shamt.
            {d.re1, d.re2, d.we} = 3'b101;
        end
        OP_OP: begin
            d.op = alu_op_of(f3, f7, 1'b1);
            {d.re1, d.re2, d.we} = 3'b111;
        end
        OP_LUI: begin
            d.op  = EX_OR;
            d.imm = {inst[31:12], 12'd0};
            d.we  = 1'b1;
        end
        OP_AUIPC: begin
            d.op  = EX_AUIPC;
            d.imm = {inst[31:12], 12'd0};
            d.we  = 1'b1;
        end
        OP_JAL: begin
            d.op  = EX_JAL;
            d.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            d.we  = 1'b1;
        end
        OP_JALR: begin
            d.op  = EX_JALR;
            d.imm = imm_itype;
            {d.re1, d.re2, d.we} = 3'b101;
        end
        OP_BRANCH: begin
            d.op  = branch_mem_op(inst[6:0], f3);
            d.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            {d.re1, d.re2, d.we} = 3'b110;
        end
        OP_LOAD: begin
            d.op  = branch_mem_op(inst[6:0], f3);
            d.imm = imm_itype;
            {d.re1, d.re2, d.we} = 3'b101;
        end
        OP_STORE: begin
            d.op  = branch_mem_op(inst[6:0], f3);
            d.imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            {d.re1, d.re2, d.we} = 3'b110;
        end
        default: d.op = EX_NOP;
    endcase
    if (d.op == EX_NOP) begin
        d.we  = 1'b0;
        d.re1 = 1'b0;
        d.re2 = 1'b0;
        d.imm = '0;
    end
    if (!d.re1) d.rs1 = '0;
    if (!d.re2) d.rs2 = '0;
    d.sel = group_of(d.op);
    return d;
endfunction

function automatic logic load_use_hit(logic re, reg_addr_t a, fwd_t ex, mem_op_e mop);
    return re && (a != '0) && (mop == MEM_READ || mop == MEM_READU) && (ex.rd == a);
endfunction

function automatic word_t pick_operand(logic re, reg_addr_t a, word_t imm, word_t rf,
                                      fwd_t ex, fwd_t mem, mem_op_e mop);
    if (!re) return imm;
    if (a == '0 || load_use_hit(re, a, ex, mop)) return '0;
    if (ex.we && ex.rd == a) return ex.data;
    if (mem.we && mem.rd == a) return mem.data;
    return rf;
endfunction

function automatic id_ex_t bubble_value();
    id_ex_t b;
    b     = '0;
    b.op  = EX_NOP;
    b.sel = RES_NOP;
    return b;
endfunction

function automatic id_ex_t stage_out(decode_t d, word_t pc, word_t rf1, word_t rf2,
                                     fwd_t ex, fwd_t mem, mem_op_e mop);
    id_ex_t e;
    e.op     = d.op;
    e.sel    = d.sel;
    e.op1    = pick_operand(d.re1, d.rs1, d.imm, rf1, ex, mem, mop);
    e.op2    = pick_operand(d.re2, d.rs2, d.imm, rf2, ex, mem, mop);
    e.pc     = pc;
    e.offset = d.imm;
    e.we     = d.we;
    e.rd     = d.rd;
    return e;
endfunction

// register rule out of reset.
function automatic id_ex_t next_state(id_ex_t cur, logic rdy, logic stall, id_ex_t fresh);
    if (!rdy) return cur;
    if (stall) return bubble_value();
    return fresh;
endfunction

`endif

// ==== sim/tb_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage import rv_id_pkg::*; ();

    localparam int CYCLES = 3000;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     rdy;
    word_t    pc;
    word_t    inst;
    word_t    rf_data1;
    word_t    rf_data2;
    fwd_t     ex_fwd;
    fwd_t     mem_fwd;
    mem_op_e  ex_mem_op;
    rf_read_t rf_read;
    logic     id_stall;
    id_ex_t   id_ex;

    int       seed;
    word_t    regs [32];
    id_ex_t   exp_q [$];
    id_ex_t   exp_state;

    `include "id_model.svh"

    id_stage dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .rdy_i       (rdy),
        .pc_i        (pc),
        .inst_i      (inst),
        .rf_data1_i  (rf_data1),
        .rf_data2_i  (rf_data2),
        .ex_fwd_i    (ex_fwd),
        .mem_fwd_i   (mem_fwd),
        .ex_mem_op_i (ex_mem_op),
        .rf_read_o   (rf_read),
        .id_stall_o  (id_stall),
        .id_ex_o     (id_ex)
    );

    always #20 clk = ~clk;

    // register file answers in the same cycle.
    assign rf_data1 = regs[rf_read.addr1];
    assign rf_data2 = regs[rf_read.addr2];

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_id_ex(string name, id_ex_t exp, id_ex_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_rf_read(string name, rf_read_t exp, rf_read_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_stall(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic wait_reset_bubble();
        int n;
        n = 0;
        while (n < 2 || id_ex.we !== 1'b0 || id_ex.op !== EX_NOP) begin
            @(posedge clk);
            #2;
            n++;
            if (n > 20) begin
                $display("reset never cleared the ID/EX register");
                stop_with_failure();
            end
        end
    endtask

    task automatic drive_random();
        word_t      r;
        word_t      d1;
        word_t      d2;
        int         grp;
        logic [6:0] opc;
        r   = $random(seed);
        grp = int'(r % 11);
        case (grp)
            0:       opc = OP_IMM;
            1:       opc = OP_OP;
            2:       opc = OP_LUI;
            3:       opc = OP_AUIPC;
            4:       opc = OP_JAL;
            5:       opc = OP_JALR;
            6:       opc = OP_BRANCH;
            7:       opc = OP_LOAD;
            8:       opc = OP_STORE;
            9:       opc = 7'b0001111; // fence is not decoded.
            default: opc = r[30:24];
        endcase
        r = $random(seed);
        inst        = r;
        inst[6:0]   = opc;
        inst[11:7]  = {2'b00, r[9:7]}; // x0..x7 so hazards are frequent.
        inst[19:15] = {2'b00, r[17:15]};
        inst[24:20] = {2'b00, r[22:20]};
        if (r[26:25] == 2'b00) inst[31:25] = F7_BASE;
        else if (r[26:25] == 2'b01) inst[31:25] = F7_ALT;
        r  = $random(seed);
        d1 = $random(seed);
        d2 = $random(seed);
        ex_fwd    = '{we: r[0], rd: {2'b00, r[3:1]}, data: d1};
        mem_fwd   = '{we: r[4], rd: {2'b00, r[7:5]}, data: d2};
        ex_mem_op = mem_op_e'(r[9:8]);
        rdy       = (r[12:10] != 3'd0);
        pc        = {d1[15:0], d2[15:2], 2'b00};
    endtask

    initial begin
        decode_t  dec;
        rf_read_t rf_exp;
        logic     stall_exp;
        id_ex_t   fresh;
        seed      = 32'ha94;
        rst_n     = 1'b0;
        rdy       = 1'b1;
        pc        = '0;
        inst      = '0;
        ex_fwd    = '0;
        mem_fwd   = '0;
        ex_mem_op = MEM_NONE;
        for (int i = 0; i < 32; i++) begin
            regs[i] = $random(seed); // x0 gets junk that must never leak out.
        end

        wait_reset_bubble();
        check_id_ex("after reset", bubble_value(), id_ex);
        rst_n     = 1'b1;
        exp_state = bubble_value();

        for (int cyc = 0; cyc < CYCLES; cyc++) begin
            drive_random();
            #16;
            dec       = decode_expect(inst);
            rf_exp    = '{re1: dec.re1, re2: dec.re2, addr1: dec.rs1, addr2: dec.rs2};
            stall_exp = load_use_hit(dec.re1, dec.rs1, ex_fwd, ex_mem_op) ||
                        load_use_hit(dec.re2, dec.rs2, ex_fwd, ex_mem_op);
            check_rf_read($sformatf("rf_read cycle %0d", cyc), rf_exp, rf_read);
            check_stall($sformatf("id_stall cycle %0d", cyc), stall_exp, id_stall);
            fresh     = stage_out(dec, pc, regs[dec.rs1], regs[dec.rs2],
                                  ex_fwd, mem_fwd, ex_mem_op);
            exp_state = next_state(exp_state, rdy, stall_exp, fresh);
            exp_q.push_back(exp_state);
            @(posedge clk);
            #2;
            check_id_ex($sformatf("id_ex cycle %0d", cyc), exp_q.pop_front(), id_ex);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
